// File: design/beam_params.svh
/*
 * beamformer dimensions
 * sample, weight and fixed point widths plus lane and channel counts
 */
`ifndef BEAM_PARAMS_SVH
`define BEAM_PARAMS_SVH

// width of one real or imaginary sample part
`define BEAM_SAMPLE_W 16

// width of one real or imaginary weight part
`define BEAM_WEIGHT_W 8

// weights are signed fixed point with this many fraction bits
`define BEAM_WEIGHT_FRAC 7

// complex samples carried in one word
`define BEAM_LANES 8

// antenna channels feeding the beam
`define BEAM_CHANNELS 4

`endif

// File: design/beam_pkg.sv
/*
 * beamformer types
 * signed sample, weight and product parts and the eight lane word
 */
`default_nettype none

`include "beam_params.svh"

package beam_pkg;

    // a 16x8 signed product needs 24 bits, and one more bit holds
    // the exact sum or difference of two such products
    localparam int PRODUCT_W = `BEAM_SAMPLE_W + `BEAM_WEIGHT_W + 1;

    // one real or imaginary sample part
    typedef logic signed [`BEAM_SAMPLE_W-1:0] sample_t;

    // one real or imaginary weight part, 1.7 fixed point
    typedef logic signed [`BEAM_WEIGHT_W-1:0] weight_t;

    // full precision products and their combination before scaling
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // lane 0 sits in the low 16 bits of the word
    // the real and imaginary halves travel as two separate words
    typedef sample_t [`BEAM_LANES-1:0] word_t;

endpackage

`default_nettype wire

// File: design/cmul_lane.sv
/*
 * complex multiply for one sample lane
 * two stage pipeline, products first, then combine, scale and wrap to 16 bits
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module cmul_lane import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  sample_t s_real,
    input  sample_t s_imag,
    input  weight_t w_real,
    input  weight_t w_imag,
    output sample_t y_real,
    output sample_t y_imag
);

    // stage one product registers, all four partial products of (s_r + j s_i)(w_r + j w_i)
    product_t prod_rr;
    product_t prod_ii;
    product_t prod_ri;
    product_t prod_ir;

    // stage two combine at full precision, then scale by the weight fraction
    product_t comb_real;
    product_t comb_imag;
    product_t scaled_real;
    product_t scaled_imag;

    // both operands are signed so the multiply sign extends into product_t
    always_ff @(posedge clock) begin
        if (!resetn) begin
            prod_rr <= '0;
            prod_ii <= '0;
            prod_ri <= '0;
            prod_ir <= '0;
        end else begin
            prod_rr <= s_real * w_real;
            prod_ii <= s_imag * w_imag;
            prod_ri <= s_real * w_imag;
            prod_ir <= s_imag * w_real;
        end
    end

    // real part is rr - ii and imaginary part is ri + ir, exact at 25 bits
    always_comb begin
        comb_real   = prod_rr - prod_ii;
        comb_imag   = prod_ri + prod_ir;
        scaled_real = comb_real >>> `BEAM_WEIGHT_FRAC;
        scaled_imag = comb_imag >>> `BEAM_WEIGHT_FRAC;
    end

    // keeping only the low sample bits wraps any overflow modulo 2^16
    always_ff @(posedge clock) begin
        if (!resetn) begin
            y_real <= '0;
            y_imag <= '0;
        end else begin
            y_real <= scaled_real[`BEAM_SAMPLE_W-1:0];
            y_imag <= scaled_imag[`BEAM_SAMPLE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/channel_weight.sv
/*
 * per channel weighting
 * captures a word and its weight on the strobe and runs eight lane multipliers
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module channel_weight import beam_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  logic    in_valid,
    input  word_t   in_real,
    input  word_t   in_imag,
    input  weight_t weight_real,
    input  weight_t weight_imag,
    output logic    weighted_valid,
    output word_t   weighted_real,
    output word_t   weighted_imag
);

    // one capture stage plus the two multiplier stages
    localparam int VALID_DEPTH = 3;

    // captured item, the weight is held next to the data it belongs to
    word_t   cap_real;
    word_t   cap_imag;
    weight_t cap_weight_real;
    weight_t cap_weight_imag;

    // strobe delayed to line up with the multiplier outputs
    logic [VALID_DEPTH-1:0] valid_pipe;

    // inputs are only looked at on a strobe
    // a weight change between strobes cannot reach an item already taken
    always_ff @(posedge clock) begin
        if (in_valid) begin
            cap_real        <= in_real;
            cap_imag        <= in_imag;
            cap_weight_real <= weight_real;
            cap_weight_imag <= weight_imag;
        end
    end

    // validity is tracked here since the lane pipelines run every cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[VALID_DEPTH-2:0], in_valid};
        end
    end

    assign weighted_valid = valid_pipe[VALID_DEPTH-1];

    // every lane shares the captured weight
    // lane results land directly in their slot of the output words
    for (genvar lane = 0; lane < `BEAM_LANES; lane++) begin : g_lane
        cmul_lane u_cmul_lane (
            .clock  (clock),
            .resetn (resetn),
            .s_real (cap_real[lane]),
            .s_imag (cap_imag[lane]),
            .w_real (cap_weight_real),
            .w_imag (cap_weight_imag),
            .y_real (weighted_real[lane]),
            .y_imag (weighted_imag[lane])
        );
    end

endmodule

`default_nettype wire

// File: design/beam_combiner.sv
/*
 * beam combiner
 * lane by lane wrapped sum of the weighted channels into one registered beam word
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module beam_combiner import beam_pkg::*; (
    input  logic                      clock,
    input  logic                      resetn,
    input  logic [`BEAM_CHANNELS-1:0] weighted_valid,
    input  word_t                     weighted_real [`BEAM_CHANNELS],
    input  word_t                     weighted_imag [`BEAM_CHANNELS],
    output logic                      beam_valid,
    output word_t                     beam_real,
    output word_t                     beam_imag
);

    // channel words with idle channels forced to zero
    word_t masked_real [`BEAM_CHANNELS];
    word_t masked_imag [`BEAM_CHANNELS];

    // combinational lane sums ahead of the output register
    word_t sum_real;
    word_t sum_imag;

    // the lane pipelines run freely, so an idle channel still shows stale data
    always_comb begin
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            masked_real[ch] = weighted_valid[ch] ? weighted_real[ch] : '0;
            masked_imag[ch] = weighted_valid[ch] ? weighted_imag[ch] : '0;
        end
    end

    // sums stay at sample width so each lane wraps modulo 2^16
    always_comb begin
        sum_real = '0;
        sum_imag = '0;
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                sum_real[lane] = sum_real[lane] + masked_real[ch][lane];
                sum_imag[lane] = sum_imag[lane] + masked_imag[ch][lane];
            end
        end
    end

    // a beam word goes out whenever at least one channel delivered
    always_ff @(posedge clock) begin
        if (!resetn) begin
            beam_valid <= 1'b0;
            beam_real  <= '0;
            beam_imag  <= '0;
        end else begin
            beam_valid <= |weighted_valid;
            beam_real  <= sum_real;
            beam_imag  <= sum_imag;
        end
    end

endmodule

`default_nettype wire

// File: design/beam_top.sv
/*
 * four channel receive beamformer
 * weights each channel's complex word and sums the channels into one beam word,
 * four cycles from input strobe to beam strobe with no back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module beam_top import beam_pkg::*; (
    input  logic                      clock,
    input  logic                      resetn,

    // per channel inputs, data and weight are taken in the strobe cycle
    input  logic [`BEAM_CHANNELS-1:0] in_valid,
    input  word_t                     in_real     [`BEAM_CHANNELS],
    input  word_t                     in_imag     [`BEAM_CHANNELS],
    input  weight_t                   weight_real [`BEAM_CHANNELS],
    input  weight_t                   weight_imag [`BEAM_CHANNELS],

    // summed beam, the consumer must take it in its strobe cycle
    output logic                      beam_valid,
    output word_t                     beam_real,
    output word_t                     beam_imag
);

    // weighted channel streams into the combiner
    logic [`BEAM_CHANNELS-1:0] weighted_valid;
    word_t                     weighted_real [`BEAM_CHANNELS];
    word_t                     weighted_imag [`BEAM_CHANNELS];

    // one weighting pipeline per antenna channel
    // each holds its own weight with its own item, three cycles deep
    for (genvar ch = 0; ch < `BEAM_CHANNELS; ch++) begin : g_channel
        channel_weight u_channel_weight (
            .clock          (clock),
            .resetn         (resetn),
            .in_valid       (in_valid[ch]),
            .in_real        (in_real[ch]),
            .in_imag        (in_imag[ch]),
            .weight_real    (weight_real[ch]),
            .weight_imag    (weight_imag[ch]),
            .weighted_valid (weighted_valid[ch]),
            .weighted_real  (weighted_real[ch]),
            .weighted_imag  (weighted_imag[ch])
        );
    end

    // all channels share the same latency, so items that strobed together
    // reach the combiner in the same cycle and are summed as one beam word
    beam_combiner u_beam_combiner (
        .clock          (clock),
        .resetn         (resetn),
        .weighted_valid (weighted_valid),
        .weighted_real  (weighted_real),
        .weighted_imag  (weighted_imag),
        .beam_valid     (beam_valid),
        .beam_real      (beam_real),
        .beam_imag      (beam_imag)
    );

endmodule

`default_nettype wire

// File: tb/beam_chk.sv
/*
 * beamformer timing checker
 * bound into the top level, watches reset and the strobe latency of the beam output
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module beam_chk import beam_pkg::*; (
    input logic                      clock,
    input logic                      resetn,
    input logic [`BEAM_CHANNELS-1:0] in_valid,
    input logic                      beam_valid
);

    // number of assertion failures, the testbench folds it into its verdict
    int unsigned violations = 0;

    // the output register clears in reset and nothing can reach it one cycle later
    reset_quiet: assert property (
        @(posedge clock) !resetn |=> !beam_valid ##1 !beam_valid
    ) else begin
        violations++;
        $error("beam_valid high during reset or just after its release");
    end

    // capture, two multiplier stages and the combiner register make four cycles
    strobe_latency: assert property (
        @(posedge clock) disable iff (!resetn)
        beam_valid == $past(|in_valid, 4)
    ) else begin
        violations++;
        $error("beam_valid does not follow the input strobes four cycles earlier");
    end

    // once out of reset the strobe must always be a clean level
    valid_known: assert property (
        @(posedge clock) disable iff (!resetn) !$isunknown(beam_valid)
    ) else begin
        violations++;
        $error("beam_valid is unknown");
    end

endmodule

// every beam_top in the simulation carries the checker
bind beam_top beam_chk u_beam_chk (
    .clock      (clock),
    .resetn     (resetn),
    .in_valid   (in_valid),
    .beam_valid (beam_valid)
);

`default_nettype wire

// File: tb/beam_tb.sv
/*
 * beamformer testbench
 * directed and random stimulus against a model of the weighting rule,
 * beam words checked lane by lane with immediate assertions
 */
`timescale 1ns/1ps
`default_nettype none

`include "beam_params.svh"

module beam_tb import beam_pkg::*; ();

    // test lengths in clock cycles, each random test ends with a drain
    localparam int DRAIN_CYCLES = 8;
    localparam int TEST_CYCLES  = 10 + (3 + DRAIN_CYCLES) + (20 + DRAIN_CYCLES)
                                + (30 + DRAIN_CYCLES) + (3 + DRAIN_CYCLES)
                                + (6 + DRAIN_CYCLES);
    localparam int MAX_CYCLES   = 16 + TEST_CYCLES + 50;

    logic                      clock;
    logic                      resetn;
    logic [`BEAM_CHANNELS-1:0] in_valid;
    word_t                     in_real     [`BEAM_CHANNELS];
    word_t                     in_imag     [`BEAM_CHANNELS];
    weight_t                   weight_real [`BEAM_CHANNELS];
    weight_t                   weight_imag [`BEAM_CHANNELS];
    logic                      beam_valid;
    word_t                     beam_real;
    word_t                     beam_imag;

    // expected beam words in strobe order, one entry per cycle with any strobe
    word_t expect_real_q [$];
    word_t expect_imag_q [$];

    int seed;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;

    beam_top u_beam_top (
        .clock       (clock),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_real     (in_real),
        .in_imag     (in_imag),
        .weight_real (weight_real),
        .weight_imag (weight_imag),
        .beam_valid  (beam_valid),
        .beam_real   (beam_real),
        .beam_imag   (beam_imag)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // the run may not outlast reset, all tests and a margin
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // real part of a weighted sample, s_r*w_r - s_i*w_i exact, then scaled and wrapped
    function automatic sample_t weigh_real(input sample_t s_r, input sample_t s_i,
                                           input weight_t w_r, input weight_t w_i);
        int exact;
        exact = int'(s_r) * int'(w_r) - int'(s_i) * int'(w_i);
        exact = exact >>> `BEAM_WEIGHT_FRAC;
        return exact[`BEAM_SAMPLE_W-1:0];
    endfunction

    // imaginary part, s_r*w_i + s_i*w_r with the same scaling
    function automatic sample_t weigh_imag(input sample_t s_r, input sample_t s_i,
                                           input weight_t w_r, input weight_t w_i);
        int exact;
        exact = int'(s_r) * int'(w_i) + int'(s_i) * int'(w_r);
        exact = exact >>> `BEAM_WEIGHT_FRAC;
        return exact[`BEAM_SAMPLE_W-1:0];
    endfunction

    // one of the two extremes of a sample, fixed for the first rounds and random after
    function automatic sample_t extreme_sample(input int round);
        if (round == 0) begin
            return 16'h8000;
        end else if (round == 1) begin
            return 16'h7fff;
        end
        return ($random(seed) & 1) ? 16'h7fff : 16'h8000;
    endfunction

    // fresh random data and complex weights on every channel
    task automatic load_random();
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                in_real[ch][lane] = sample_t'($random(seed));
                in_imag[ch][lane] = sample_t'($random(seed));
            end
            weight_real[ch] = weight_t'($random(seed));
            weight_imag[ch] = weight_t'($random(seed));
        end
    endtask

    // apply one input cycle and queue the beam word the rule predicts for it
    task automatic drive_cycle(input logic [`BEAM_CHANNELS-1:0] valid);
        word_t exp_real;
        word_t exp_imag;
        int    acc_real;
        int    acc_imag;
        in_valid = valid;
        if (|valid) begin
            for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                acc_real = 0;
                acc_imag = 0;
                // channels without a strobe add nothing to the lane
                for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                    if (valid[ch]) begin
                        acc_real += weigh_real(in_real[ch][lane], in_imag[ch][lane],
                                               weight_real[ch], weight_imag[ch]);
                        acc_imag += weigh_imag(in_real[ch][lane], in_imag[ch][lane],
                                               weight_real[ch], weight_imag[ch]);
                    end
                end
                exp_real[lane] = acc_real[`BEAM_SAMPLE_W-1:0];
                exp_imag[lane] = acc_imag[`BEAM_SAMPLE_W-1:0];
            end
            expect_real_q.push_back(exp_real);
            expect_imag_q.push_back(exp_imag);
        end
        @(posedge clock);
        #2;
    endtask

    // idle cycles until every item in flight has reached the output
    task automatic drain_pipeline();
        repeat (DRAIN_CYCLES) drive_cycle('0);
    endtask

    task automatic report_test(input string name);
        $display("%s done, %0d checks passed, %0d failed so far", name, pass_count, fail_count);
    endtask

    // beam words are compared mid cycle, well away from the clock edge
    always @(negedge clock) begin
        word_t exp_real;
        word_t exp_imag;
        if (resetn && beam_valid) begin
            if (expect_real_q.size() == 0) begin
                $display("a beam word arrived while no item was in flight");
                fail_count++;
            end else begin
                exp_real = expect_real_q.pop_front();
                exp_imag = expect_imag_q.pop_front();
                for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                    assert (beam_real[lane] === exp_real[lane]) pass_count++;
                    else begin
                        $display("FAIL beam_real[%0d] expected %h actual %h",
                                 lane, exp_real[lane], beam_real[lane]);
                        fail_count++;
                    end
                    assert (beam_imag[lane] === exp_imag[lane]) pass_count++;
                    else begin
                        $display("FAIL beam_imag[%0d] expected %h actual %h",
                                 lane, exp_imag[lane], beam_imag[lane]);
                        fail_count++;
                    end
                end
            end
        end
    end

    initial begin
        int total_fail;
        seed     = 32'he2012750;
        resetn   = 1'b0;
        in_valid = '0;
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            in_real[ch]     = '0;
            in_imag[ch]     = '0;
            weight_real[ch] = '0;
            weight_imag[ch] = '0;
        end
        repeat (16) @(posedge clock);
        #2;
        resetn = 1'b1;

        // quiet output straight after reset
        repeat (10) begin
            @(negedge clock);
            assert (beam_valid === 1'b0) pass_count++;
            else begin
                $display("FAIL beam_valid expected %h actual %h", 1'b0, beam_valid);
                fail_count++;
            end
            assert (beam_real === '0 && beam_imag === '0) pass_count++;
            else begin
                $display("FAIL beam_real expected %h actual %h", 128'h0, beam_real);
                $display("FAIL beam_imag expected %h actual %h", 128'h0, beam_imag);
                fail_count++;
            end
            @(posedge clock);
            #2;
        end
        report_test("idle after reset");

        // a weight of 64 is one half, so each lane of channel 0 comes out halved
        for (int k = 0; k < 3; k++) begin
            load_random();
            weight_real[0] = 8'sd64;
            weight_imag[0] = '0;
            drive_cycle(4'b0001);
        end
        drain_pipeline();
        report_test("single channel half weight");

        // back to back strobes on every channel keep four items in flight
        repeat (20) begin
            load_random();
            drive_cycle('1);
        end
        drain_pipeline();
        report_test("all channels back to back");

        // random channel subsets, with some cycles where no channel strobes
        for (int k = 0; k < 30; k++) begin
            load_random();
            if (k % 7 == 3) begin
                drive_cycle('0);
            end else begin
                drive_cycle(4'($random(seed)));
            end
        end
        drain_pipeline();
        report_test("random channel subsets");

        // full scale samples times -128 overflow the sample width and wrap
        for (int k = 0; k < 3; k++) begin
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                weight_real[ch] = 8'h80;
                weight_imag[ch] = 8'h80;
                for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                    in_real[ch][lane] = extreme_sample(k);
                    in_imag[ch][lane] = extreme_sample(k);
                end
            end
            drive_cycle('1);
        end
        drain_pipeline();
        report_test("full scale wrap");

        // new weights and data while idle must not touch the item already taken
        load_random();
        drive_cycle('1);
        repeat (5) begin
            load_random();
            drive_cycle('0);
        end
        drain_pipeline();
        report_test("weight change after strobe");

        total_fail = fail_count + u_beam_top.u_beam_chk.violations;
        if (expect_real_q.size() != 0) begin
            $display("%0d expected beam words never arrived", expect_real_q.size());
            total_fail++;
        end
        $display("checks passed %0d, checks failed %0d", pass_count, total_fail);
        if (total_fail == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: beam.f
+incdir+design
design/beam_pkg.sv
design/cmul_lane.sv
design/channel_weight.sv
design/beam_combiner.sv
design/beam_top.sv
tb/beam_chk.sv
tb/beam_tb.sv

// File: Bender.yml
package:
  name: beam

sources:
  # synthesizable beamformer datapath
  - include_dirs:
      - design
    files:
      - design/beam_pkg.sv
      - design/cmul_lane.sv
      - design/channel_weight.sv
      - design/beam_combiner.sv
      - design/beam_top.sv

  # testbench and bound checker
  - target: test
    include_dirs:
      - design
    files:
      - tb/beam_chk.sv
      - tb/beam_tb.sv
